// File: hw/wfd_config.svh
// width, channel count and fill fifo depth macros for the wfd master readout path
`ifndef WFD_CONFIG_SVH
`define WFD_CONFIG_SVH

// channel fpgas feeding the master, one data stream each
`define WFD_N_CHAN 2

`define WFD_FILL_W 24   // fill number
`define WFD_CHAN_W 32   // channel link word
`define WFD_DAQ_W  64   // amc13 daq word

// data word count carried in the trailer
`define WFD_CNT_W 16

// completed fills that may wait for readout
`define WFD_FILL_FIFO_DEPTH 4

`endif

// File: hw/wfd_pkg.sv
// vector typedefs and fsm state enums shared by the wfd readout modules
`include "wfd_config.svh"

package wfd_pkg;

    typedef logic [`WFD_FILL_W-1:0] fill_num_t;  // fill number handed out per trigger
    typedef logic [`WFD_CHAN_W-1:0] chan_word_t; // one channel stream word
    typedef logic [`WFD_DAQ_W-1:0]  daq_word_t;  // one word towards the amc13
    typedef logic [`WFD_N_CHAN-1:0] chan_mask_t; // bit per channel fpga
    typedef logic [$clog2(`WFD_N_CHAN)-1:0] chan_id_t;
    typedef logic [`WFD_CNT_W-1:0]  word_count_t;

    // trigger manager
    typedef enum logic [1:0] {
        TM_IDLE,      // armed
        TM_WAIT_DONE, // channels acquiring
        TM_PUSH       // fill number waiting for the fifo
    } tm_state_t;

    // event builder, one pass per fill
    typedef enum logic [1:0] {
        EB_IDLE,
        EB_HEADER,
        EB_DATA,
        EB_TRAILER
    } eb_state_t;

endpackage

// File: hw/trigger_manager.sv
// trigger manager: trigger acceptance, acquisition pulses, fill numbering, done collection
`timescale 1ns/1ns
`include "wfd_config.svh"

module trigger_manager (
    input  logic                clk125,
    input  logic                rst_n,
    input  logic                trigger,       // one-cycle pulse
    input  logic                dtm_busy,      // event builder reading out
    input  wfd_pkg::chan_mask_t chan_done,     // one-cycle done pulses
    output wfd_pkg::chan_mask_t acq_trigs,     // go pulse to every channel
    output logic                fill_in_valid,
    output wfd_pkg::fill_num_t  fill_in_data,
    input  logic                fill_in_ready
);
    import wfd_pkg::*;

    tm_state_t  state;
    fill_num_t  fill_cnt;   // next number to hand out
    chan_mask_t done_mask;  // sticky, one bit per channel
    logic       accept;     // trigger taken this cycle

    // only an idle manager with an idle readout takes a trigger
    assign accept = (state == TM_IDLE) && trigger && !dtm_busy;

    assign fill_in_valid = (state == TM_PUSH); // held until the fifo takes it

    always_ff @(posedge clk125) begin
        if (!rst_n) begin
            state     <= TM_IDLE;
            fill_cnt  <= '0;
            done_mask <= '0;
            acq_trigs <= '0;
        end else begin
            acq_trigs <= {`WFD_N_CHAN{accept}}; // single cycle, all channels at once
            case (state)
                TM_IDLE: begin
                    if (accept) begin
                        fill_cnt  <= fill_cnt + fill_num_t'(1);
                        done_mask <= '0;          // fresh mask per fill
                        state     <= TM_WAIT_DONE;
                    end
                end
                TM_WAIT_DONE: begin
                    done_mask <= done_mask | chan_done; // latch pulses as they come
                    if (&done_mask) begin
                        state <= TM_PUSH;         // one cycle after the mask fills up
                    end
                end
                TM_PUSH: begin
                    if (fill_in_ready) begin
                        state <= TM_IDLE;
                    end
                end
                default: state <= TM_IDLE;
            endcase
        end
    end

    // number is fixed together with the acquisition pulse
    always_ff @(posedge clk125) begin
        if (accept) begin
            fill_in_data <= fill_cnt;
        end
    end

    // back-to-back pulses would start a second acquisition on the channels
    assert property (@(posedge clk125) disable iff (!rst_n)
        (|acq_trigs) |=> !(|acq_trigs))
        else $error("acq_trigs high on two consecutive cycles");

endmodule

// File: hw/fill_num_fifo.sv
// first-word-fall-through fifo of completed fill numbers
`timescale 1ns/1ns
`include "wfd_config.svh"

module fill_num_fifo #(
    parameter int DEPTH = `WFD_FILL_FIFO_DEPTH
) (
    input  logic               clk125,
    input  logic               rst_n,
    input  logic               fill_in_valid,
    input  wfd_pkg::fill_num_t fill_in_data,
    output logic               fill_in_ready,   // low when full
    output logic               fill_out_valid,
    output wfd_pkg::fill_num_t fill_out_data,   // head entry valid with fill_out_valid
    input  logic               fill_out_ready
);
    import wfd_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1); // wrap point
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    fill_num_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;   // occupancy
    logic             wr_en;
    logic             rd_en;

    assign fill_in_ready  = (count != FULL_CNT);
    assign fill_out_valid = (count != '0);  // rises the cycle after the first push
    assign fill_out_data  = mem[rd_ptr];    // fall through

    assign wr_en = fill_in_valid && fill_in_ready;
    assign rd_en = fill_out_valid && fill_out_ready;

    always_ff @(posedge clk125) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // none or both
            endcase
        end
    end

    always_ff @(posedge clk125) begin
        if (wr_en) mem[wr_ptr] <= fill_in_data;
    end

    // overflow or underflow would corrupt the fill order
    // equal pointers mean empty or full and the count tells which
    assert property (@(posedge clk125) disable iff (!rst_n)
        !(wr_en && wr_ptr == rd_ptr && count != '0) &&
        !(rd_en && wr_ptr == rd_ptr && count != FULL_CNT))
        else $error("fill fifo written while full or read while empty");

endmodule

// File: hw/channel_rx_arbiter.sv
// packet-wise round-robin merge of the channel data streams
`timescale 1ns/1ns
`include "wfd_config.svh"

module channel_rx_arbiter (
    input  logic                                  clk125,
    input  logic                                  rst_n,
    input  wfd_pkg::chan_mask_t                   chan_valid,
    input  wfd_pkg::chan_mask_t                   chan_last,
    input  wfd_pkg::chan_word_t [`WFD_N_CHAN-1:0] chan_data,
    output wfd_pkg::chan_mask_t                   chan_ready,
    output logic                                  rx_valid,
    output logic                                  rx_last,
    output wfd_pkg::chan_word_t                   rx_data,
    output wfd_pkg::chan_id_t                     rx_chan,   // source of the current word
    input  logic                                  rx_ready
);
    import wfd_pkg::*;

    chan_id_t grant;     // registered owner
    chan_id_t sel;       // stream passed through this cycle
    chan_id_t sel_nxt;   // the other stream
    chan_id_t grant_nxt;
    logic     locked;    // inside a packet, grant frozen
    logic     xfer;

    assign grant_nxt = grant + 1'b1;
    assign sel_nxt   = sel + 1'b1;

    // between packets an idle owner yields to a waiting channel
    always_comb begin
        sel = grant;
        if (!locked && !chan_valid[grant] && chan_valid[grant_nxt]) begin
            sel = grant_nxt;
        end
    end

    // zero latency mux
    assign rx_valid = chan_valid[sel];
    assign rx_last  = chan_last[sel];
    assign rx_data  = chan_data[sel];
    assign rx_chan  = sel;
    assign xfer     = rx_valid && rx_ready;

    always_comb begin
        chan_ready      = '0;
        chan_ready[sel] = rx_ready;  // nobody else sees ready
    end

    always_ff @(posedge clk125) begin
        if (!rst_n) begin
            grant  <= '0;     // channel 0 first
            locked <= 1'b0;
        end else if (xfer) begin
            if (rx_last) begin
                locked <= 1'b0;
                grant  <= chan_valid[sel_nxt] ? sel_nxt : sel; // rotate if the other waits
            end else begin
                locked <= 1'b1;
                grant  <= sel;
            end
        end
    end

    assert property (@(posedge clk125) disable iff (!rst_n) $onehot0(chan_ready))
        else $error("ready given to more than one channel");

    // a packet is never interleaved with the other stream
    assert property (@(posedge clk125) disable iff (!rst_n)
        (xfer && !rx_last) |=> rx_chan == $past(rx_chan))
        else $error("channel switched inside a packet");

endmodule

// File: hw/event_builder.sv
// event builder: daq header, channel data and trailer per queued fill number
`timescale 1ns/1ns
`include "wfd_config.svh"

module event_builder (
    input  logic               clk125,
    input  logic               rst_n,
    input  logic               fill_out_valid,
    input  wfd_pkg::fill_num_t fill_out_data,
    output logic               fill_out_ready,
    input  logic               rx_valid,
    input  logic               rx_last,
    input  wfd_pkg::chan_word_t rx_data,
    input  wfd_pkg::chan_id_t  rx_chan,
    output logic               rx_ready,
    output logic               daq_valid,
    output logic               daq_header,   // first word of the event
    output logic               daq_trailer,  // last word of the event
    output wfd_pkg::daq_word_t daq_data,
    input  logic               daq_ready,
    output logic               dtm_busy      // fill taken, trailer not yet sent
);
    import wfd_pkg::*;

    localparam int HDR_PAD  = `WFD_DAQ_W - `WFD_FILL_W;                 // above the fill number
    localparam int DATA_PAD = `WFD_DAQ_W - `WFD_CHAN_W - $bits(chan_id_t);
    localparam int TRL_PAD  = `WFD_DAQ_W - 32 - `WFD_FILL_W;            // fill at bit 32
    localparam int CNT_PAD  = 32 - `WFD_CNT_W;
    localparam chan_id_t LAST_PKT = chan_id_t'(`WFD_N_CHAN - 1);

    eb_state_t   state;
    fill_num_t   fill_q;     // fill being read out
    word_count_t word_cnt;   // data words so far
    chan_id_t    pkt_cnt;    // packet ends so far
    logic        fill_xfer;
    logic        rx_xfer;

    // a stalled daq link stops both inputs
    assign fill_out_ready = (state == EB_IDLE) && daq_ready;
    assign rx_ready       = (state == EB_DATA) && daq_ready;
    assign fill_xfer      = fill_out_valid && fill_out_ready;
    assign rx_xfer        = rx_valid && rx_ready;

    always_ff @(posedge clk125) begin
        if (!rst_n) begin
            state       <= EB_IDLE;
            daq_valid   <= 1'b0;
            daq_header  <= 1'b0;
            daq_trailer <= 1'b0;
            dtm_busy    <= 1'b0;
            word_cnt    <= '0;
            pkt_cnt     <= '0;
        end else if (daq_ready) begin   // output slot free or being taken
            daq_valid   <= 1'b0;
            daq_header  <= 1'b0;
            daq_trailer <= 1'b0;
            case (state)
                EB_IDLE: begin
                    dtm_busy <= fill_xfer;  // any pending trailer leaves on this edge
                    if (fill_xfer) begin
                        word_cnt <= '0;
                        pkt_cnt  <= '0;
                        state    <= EB_HEADER;
                    end
                end
                EB_HEADER: begin
                    daq_valid  <= 1'b1;
                    daq_header <= 1'b1;
                    state      <= EB_DATA;
                end
                EB_DATA: begin
                    if (rx_xfer) begin
                        daq_valid <= 1'b1;
                        word_cnt  <= word_cnt + 1'b1;
                        if (rx_last) begin
                            pkt_cnt <= pkt_cnt + 1'b1;
                            if (pkt_cnt == LAST_PKT) state <= EB_TRAILER; // every channel in
                        end
                    end
                end
                EB_TRAILER: begin
                    daq_valid   <= 1'b1;
                    daq_trailer <= 1'b1;
                    state       <= EB_IDLE;
                end
                default: state <= EB_IDLE;
            endcase
        end
    end

    // output word and captured fill number
    always_ff @(posedge clk125) begin
        if (fill_xfer) fill_q <= fill_out_data;
        if (daq_ready) begin
            case (state)
                EB_HEADER:  daq_data <= {{HDR_PAD{1'b0}}, fill_q};
                EB_DATA: begin
                    if (rx_xfer) daq_data <= {{DATA_PAD{1'b0}}, rx_chan, rx_data};
                end
                EB_TRAILER: daq_data <= {{TRL_PAD{1'b0}}, fill_q, {CNT_PAD{1'b0}}, word_cnt};
                default:    daq_data <= daq_data;
            endcase
        end
    end

    // amc13 side needs the word held through a stall
    assert property (@(posedge clk125) disable iff (!rst_n)
        (daq_valid && !daq_ready) |=> daq_valid && $stable(daq_data))
        else $error("daq word changed while stalled");

endmodule

// File: hw/wfd_readout_top.sv
// readout top: trigger manager, fill fifo, channel arbiter and event builder
`timescale 1ns/1ns
`include "wfd_config.svh"

module wfd_readout_top (
    input  logic                                  clk125,
    input  logic                                  rst_n,
    input  logic                                  trigger,
    input  wfd_pkg::chan_mask_t                   chan_done,
    output wfd_pkg::chan_mask_t                   acq_trigs,
    input  wfd_pkg::chan_mask_t                   chan_valid,
    input  wfd_pkg::chan_mask_t                   chan_last,
    input  wfd_pkg::chan_word_t [`WFD_N_CHAN-1:0] chan_data,
    output wfd_pkg::chan_mask_t                   chan_ready,
    output logic                                  daq_valid,
    output logic                                  daq_header,
    output logic                                  daq_trailer,
    output wfd_pkg::daq_word_t                    daq_data,
    input  logic                                  daq_ready
);
    import wfd_pkg::*;

    logic       dtm_busy;
    // trigger manager to fifo
    logic       fill_in_valid;
    logic       fill_in_ready;
    fill_num_t  fill_in_data;
    // fifo to event builder
    logic       fill_out_valid;
    logic       fill_out_ready;
    fill_num_t  fill_out_data;
    // merged channel stream
    logic       rx_valid;
    logic       rx_last;
    logic       rx_ready;
    chan_word_t rx_data;
    chan_id_t   rx_chan;

    trigger_manager i_tm (
        .clk125, .rst_n, .trigger, .dtm_busy, .chan_done, .acq_trigs,
        .fill_in_valid, .fill_in_data, .fill_in_ready
    );

    fill_num_fifo #(.DEPTH(`WFD_FILL_FIFO_DEPTH)) i_fill_fifo (
        .clk125, .rst_n, .fill_in_valid, .fill_in_data, .fill_in_ready,
        .fill_out_valid, .fill_out_data, .fill_out_ready
    );

    channel_rx_arbiter i_rx_arb (
        .clk125, .rst_n, .chan_valid, .chan_last, .chan_data, .chan_ready,
        .rx_valid, .rx_last, .rx_data, .rx_chan, .rx_ready
    );

    event_builder i_eb (
        .clk125, .rst_n, .fill_out_valid, .fill_out_data, .fill_out_ready,
        .rx_valid, .rx_last, .rx_data, .rx_chan, .rx_ready,
        .daq_valid, .daq_header, .daq_trailer, .daq_data, .daq_ready, .dtm_busy
    );

endmodule

// File: bench/wfd_readout_tb.sv
// wfd_readout_top testbench with clock, reset, channel models, daq sink, reference function and checks
`timescale 1ns/1ns
`include "wfd_config.svh"

module wfd_readout_tb;
    import wfd_pkg::*;

    localparam int N_TESTS        = 4;
    localparam int MAX_EVENTS     = 8;   // longest test
    localparam int TIMEOUT_CYCLES = N_TESTS * MAX_EVENTS * 200;
    localparam int KIND_HDR = 0;
    localparam int KIND_DATA = 1;
    localparam int KIND_TRL = 2;

    logic clk125;
    logic rst_n;
    logic trigger;
    logic daq_ready;
    logic daq_valid;
    logic daq_header;
    logic daq_trailer;
    daq_word_t  daq_data;
    chan_mask_t chan_done, acq_trigs, chan_valid, chan_last, chan_ready;
    chan_word_t [`WFD_N_CHAN-1:0] chan_data;

    int seed = 32'h30e6;
    int errors, checks, test_no, base_errors;
    int events_done, hdr_cnt, acq_cnt, cycles;
    logic rand_ready;
    logic trig_seen;   // first trigger driven
    logic in_event;
    fill_num_t next_fill;   // model of the fill counter
    fill_num_t cur_fill;
    fill_num_t  exp_fill_q [$];
    chan_word_t sent_q0 [$];
    chan_word_t sent_q1 [$];
    int         len_q0 [$];
    int         len_q1 [$];
    int         xfer_q [$];   // channel of each word in transfer order

    wfd_readout_top i_dut (
        .clk125, .rst_n, .trigger, .chan_done, .acq_trigs,
        .chan_valid, .chan_last, .chan_data, .chan_ready,
        .daq_valid, .daq_header, .daq_trailer, .daq_data, .daq_ready
    );

    initial begin
        clk125 = 1'b0;
        forever #4 clk125 = ~clk125;   // 125 MHz
    end

    // channel fpga models that acquire and then send one packet per acq pulse
    for (genvar c = 0; c < `WFD_N_CHAN; c++) begin : g_chan
        logic       valid;
        logic       last;
        logic       done;
        chan_word_t data;
        int         n;
        int         len;
        initial begin
            valid = 1'b0;
            last  = 1'b0;
            done  = 1'b0;
            data  = '0;
            forever begin
                @(posedge clk125);
                #1;
                if (acq_trigs[c]) begin
                    n = 2 + ($unsigned($random(seed)) % 9);   // 2..10 cycles
                    repeat (n) @(posedge clk125);
                    #1 done = 1'b1;
                    @(posedge clk125);
                    #1 done = 1'b0;
                    len = 1 + ($unsigned($random(seed)) % 8);  // 1..8 words
                    if (c == 0) len_q0.push_back(len);
                    else len_q1.push_back(len);
                    for (int i = 0; i < len; i++) begin
                        data  = $random(seed);
                        valid = 1'b1;
                        last  = (i == len - 1);
                        if (c == 0) sent_q0.push_back(data);
                        else sent_q1.push_back(data);
                        do @(negedge clk125); while (!chan_ready[c]); // taken at next edge
                        xfer_q.push_back(c);
                        @(posedge clk125);
                        #1;
                    end
                    valid = 1'b0;
                    last  = 1'b0;
                end
            end
        end
    end

    assign chan_valid = {g_chan[1].valid, g_chan[0].valid};
    assign chan_last  = {g_chan[1].last, g_chan[0].last};
    assign chan_done  = {g_chan[1].done, g_chan[0].done};
    assign chan_data  = {g_chan[1].data, g_chan[0].data};

    // daq sink with steady or coin-flip ready
    initial begin
        daq_ready = 1'b1;
        forever begin
            @(posedge clk125);
            #1 daq_ready = rand_ready ? (($random(seed) & 1) != 0) : 1'b1;
        end
    end

    // expected daq word from the event word rule
    function automatic daq_word_t expect_word(input int kind, input fill_num_t fill,
                                              input logic chan, input chan_word_t word,
                                              input int count);
        daq_word_t w;
        w = '0;
        case (kind)
            KIND_HDR: w[23:0] = fill;
            KIND_DATA: begin
                w[32]   = chan;   // channel id
                w[31:0] = word;
            end
            default: begin
                w[55:32] = fill;
                w[15:0]  = count[15:0];   // data words in the event
            end
        endcase
        return w;
    endfunction

    task automatic check_daq_word();
        daq_word_t  exp;
        chan_word_t w;
        int         cnt;
        int         ch;
        checks++;
        w   = '0;
        cnt = 0;
        ch  = 0;
        if (daq_header) begin
            if (in_event || daq_trailer) begin
                $display("header flag out of place at %0t", $time);
                errors++;
            end
            if (exp_fill_q.size() == 0) begin
                $display("event header with no accepted trigger at %0t", $time);
                errors++;
            end else cur_fill = exp_fill_q.pop_front();
            in_event = 1'b1;
            hdr_cnt++;
            exp = expect_word(KIND_HDR, cur_fill, 1'b0, '0, 0);
        end else if (daq_trailer) begin
            if (len_q0.size() == 0 || len_q1.size() == 0) begin
                $display("trailer before every channel sent a packet at %0t", $time);
                errors++;
            end else cnt = len_q0.pop_front() + len_q1.pop_front();
            if (sent_q0.size() != 0 || sent_q1.size() != 0 || xfer_q.size() != 0) begin
                $display("channel words lost before the trailer at %0t", $time);
                errors++;
                sent_q0.delete();
                sent_q1.delete();
                xfer_q.delete();
            end
            exp = expect_word(KIND_TRL, cur_fill, 1'b0, '0, cnt);
            in_event = 1'b0;
            events_done++;
        end else begin
            if (!in_event) begin
                $display("data word outside an event at %0t", $time);
                errors++;
            end
            if (xfer_q.size() == 0) begin
                $display("data word with no channel transfer behind it at %0t", $time);
                errors++;
            end else begin
                ch = xfer_q.pop_front();   // channels hand words over in this order
                if (ch == 0) w = sent_q0.pop_front();
                else w = sent_q1.pop_front();
            end
            exp = expect_word(KIND_DATA, cur_fill, ch[0], w, 0);
        end
        if (daq_data !== exp) begin
            $display("Fail at %0t: daq word %h, expected %h", $time, daq_data, exp);
            errors++;
        end
    endtask

    // compare process runs mid-cycle where every signal is settled
    always @(negedge clk125) begin
        if (rst_n && daq_valid && daq_ready) check_daq_word();
        if (rst_n && acq_trigs != '0) begin
            acq_cnt++;
            if (acq_trigs != '1) begin
                $display("Fail at %0t: acq_trigs %b, expected all ones", $time, acq_trigs);
                errors++;
            end
        end
        if (rst_n && !trig_seen && (acq_trigs != '0 || daq_valid)) begin
            $display("Fail at %0t: activity on acq_trigs or daq_valid before a trigger", $time);
            errors++;
        end
    end

    task automatic pulse_trigger();
        trigger = 1'b1;
        @(posedge clk125);
        #1 trigger = 1'b0;
    endtask

    // one accepted trigger through to its trailer with optional extra triggers while busy
    task automatic run_event(input logic extra);
        int done_before;
        done_before = events_done;
        trig_seen   = 1'b1;
        exp_fill_q.push_back(next_fill);
        next_fill++;
        pulse_trigger();
        if (acq_trigs !== '1) begin
            $display("Fail at %0t: no acq pulse the cycle after the trigger", $time);
            errors++;
        end
        @(posedge clk125);
        #1;
        if (acq_trigs !== '0) begin
            $display("Fail at %0t: acq pulse longer than one cycle", $time);
            errors++;
        end
        if (extra) begin
            pulse_trigger();                   // channels still acquiring
            wait (hdr_cnt == done_before + 1);
            @(posedge clk125);
            #1;
            pulse_trigger();                   // readout under way
        end
        wait (events_done == done_before + 1);
        @(posedge clk125);
        #1;
    endtask

    task automatic report_test(input string name);
        test_no++;
        if (acq_cnt != int'(next_fill)) begin
            $display("Fail at %0t: acq pulse count %0d, expected %0d", $time, acq_cnt,
                     next_fill);
            errors++;
        end
        $display("test %0d %s: %0d errors", test_no, name, errors - base_errors);
        base_errors = errors;
    endtask

    initial begin
        rst_n = 1'b0;
        trigger = 1'b0;
        rand_ready = 1'b0;
        trig_seen = 1'b0;
        in_event = 1'b0;
        next_fill = '0;
        repeat (10) @(posedge clk125);
        #1 rst_n = 1'b1;
        repeat (20) @(posedge clk125);
        #1;
        report_test("idle after reset");
        repeat (4) run_event(1'b0);
        report_test("fill numbering");
        repeat (4) run_event(1'b1);
        report_test("busy triggers ignored");
        rand_ready = 1'b1;
        repeat (MAX_EVENTS) run_event(1'b0);
        rand_ready = 1'b0;
        report_test("random daq_ready");
        $display("tests %0d, checks %0d, errors %0d", test_no, checks, errors);
        if (errors == 0) $display("Done: no errors");
        else $display("Done: errors found");
        $finish;
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk125);
            cycles++;
        end
        $display("timeout after %0d cycles, events stopped arriving", cycles);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: sim.f
+incdir+hw
hw/wfd_pkg.sv
hw/trigger_manager.sv
hw/fill_num_fifo.sv
hw/channel_rx_arbiter.sv
hw/event_builder.sv
hw/wfd_readout_top.sv
bench/wfd_readout_tb.sv

// File: Bender.yml
package:
  name: wfd_readout

sources:
  - include_dirs:
      - hw
    files:
      - hw/wfd_pkg.sv
      - hw/trigger_manager.sv
      - hw/fill_num_fifo.sv
      - hw/channel_rx_arbiter.sv
      - hw/event_builder.sv
      - hw/wfd_readout_top.sv
      - target: test
        files:
          - bench/wfd_readout_tb.sv
